//--- include/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Frame payload width
`define UART_DATA_W 8

// Oversample ticks per serial bit
`define UART_OVERSAMPLE 16

// Baud divisor counter width, holds the 300 baud divisor
`define UART_DIV_W 16

// Host side FIFO entries, kept a power of two
`define UART_FIFO_DEPTH 4

// Credits granted to the FIFO out of reset
`define UART_CREDITS 4

`endif

//--- project.f
+incdir+include
src/uart_cfg_pkg.sv
src/uart_frame_pkg.sv
src/uart_sample_if.sv
src/uart_baud_gen.sv
src/uart_rx_sampler.sv
src/uart_receiver.sv
src/uart_rx_fifo.sv
src/uart_rx_top.sv
verification/uart_rx_tb.sv

//--- src/uart_baud_gen.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_baud_gen import uart_cfg_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_en,
    input  baud_sel_t  baud_select,
    uart_sample_if.gen sample_if
);
    logic [`UART_DIV_W-1:0] divisor;
    logic [`UART_DIV_W-1:0] count;      // Cycles left to next tick
    baud_sel_t              sel_q;      // Rate seen last cycle
    logic                   sel_change;
    logic                   reload;

    assign divisor    = baud_divisor(baud_select);
    assign sel_change = (baud_select != sel_q);

    // Fresh phase on enable or rate change
    assign reload = !rx_en || sel_change;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            sel_q <= BAUD_300;
        end else begin
            sel_q <= baud_select;
            if (reload || count == '0) begin
                count <= divisor - 1'b1; // Period of exactly divisor cycles
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Tick on terminal count, never while reloading
    assign sample_if.tick = !reload && (count == '0);

endmodule

//--- src/uart_cfg_pkg.sv
`include "uart_params.svh"

package uart_cfg_pkg;

    // Rate select, slowest first
    typedef enum logic [2:0] {
        BAUD_300,
        BAUD_1200,
        BAUD_4800,
        BAUD_9600,
        BAUD_19200,
        BAUD_38400,
        BAUD_57600,
        BAUD_115200
    } baud_sel_t;

    // clk cycles per 16x tick
    // 50 MHz / (16 * rate), rounded to nearest
    function automatic logic [`UART_DIV_W-1:0] baud_divisor(input baud_sel_t sel);
        logic [`UART_DIV_W-1:0] div;
        case (sel)
            BAUD_300:    div = `UART_DIV_W'(10417);
            BAUD_1200:   div = `UART_DIV_W'(2604);
            BAUD_4800:   div = `UART_DIV_W'(651);
            BAUD_9600:   div = `UART_DIV_W'(326);
            BAUD_19200:  div = `UART_DIV_W'(163);
            BAUD_38400:  div = `UART_DIV_W'(81);
            BAUD_57600:  div = `UART_DIV_W'(54);
            default:     div = `UART_DIV_W'(27); // 115200
        endcase
        return div;
    endfunction

endpackage

//--- src/uart_frame_pkg.sv
package uart_frame_pkg;

    // Receiver FSM states
    typedef enum logic [2:0] {
        DISABLED,     // rx_en low
        IDLE,         // Line idle, waiting for a falling edge
        START_BIT,    // Confirming start at mid-bit
        DATA,         // Eight data bits, LSB first
        PARITY,       // Even parity bit
        STOP,         // Stop bit, push on good frame
        PERROR_LOCK,  // Held until rx_en drops
        FERROR_LOCK   // Held until rx_en drops
    } rx_state_t;

    // Error flags out of the receiver
    typedef struct packed {
        logic ferror; // Stop bit low or noisy vote
        logic perror; // Even parity mismatch
    } rx_status_t;

endpackage

//--- src/uart_receiver.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_receiver import uart_cfg_pkg::*, uart_frame_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rx_en,
    input  baud_sel_t               baud_select,
    input  logic                    rxd,
    output logic                    push,
    output logic [`UART_DATA_W-1:0] push_data,
    output rx_status_t              status
);
    localparam int PHASE_W   = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_CNT_W = $clog2(`UART_DATA_W);
    // Phase right after tick 9 has landed in the vote history
    localparam int DECIDE_PHASE = `UART_OVERSAMPLE / 2 + 1;

    rx_state_t            state;
    rx_state_t            state_next;
    logic [PHASE_W-1:0]   phase;    // Tick count within the current bit
    logic [BIT_CNT_W-1:0] bit_cnt;  // Data bits taken
    logic                 tick_q;   // Tick delayed past the sampler update
    logic                 decide;   // Mid-bit decision strobe

    uart_sample_if sample_bus ();

    uart_baud_gen u_baud_gen (
        .clk         (clk),
        .reset       (reset),
        .rx_en       (rx_en),
        .baud_select (baud_select),
        .sample_if   (sample_bus.gen)
    );

    uart_rx_sampler u_sampler (
        .clk       (clk),
        .reset     (reset),
        .rxd       (rxd),
        .sample_if (sample_bus.sampler)
    );

    assign decide = tick_q && (phase == PHASE_W'(DECIDE_PHASE));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= DISABLED;
            phase   <= '0;
            bit_cnt <= '0;
            tick_q  <= 1'b0;
        end else begin
            state  <= state_next;
            tick_q <= sample_bus.tick;
            if (state == IDLE) begin
                phase <= '0; // Realign on every start edge
            end else if (sample_bus.tick) begin
                phase <= phase + 1'b1;
            end
            if (state == START_BIT) begin
                bit_cnt <= '0;
            end else if (state == DATA && decide) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // LSB first so shift in from the top
    always_ff @(posedge clk) begin
        if (state == DATA && decide) begin
            push_data <= {sample_bus.bit_value, push_data[`UART_DATA_W-1:1]};
        end
    end

    always_comb begin
        state_next = state;
        push       = 1'b0;
        if (!rx_en) begin
            state_next = DISABLED; // Also the only way out of a lock
        end else begin
            case (state)
                DISABLED: state_next = IDLE;
                IDLE: begin
                    if (!sample_bus.rxd_sync) state_next = START_BIT;
                end
                START_BIT: begin
                    if (decide) begin
                        if (sample_bus.bit_value) state_next = IDLE; // Glitch dropped quietly
                        else if (!sample_bus.bit_stable) state_next = FERROR_LOCK;
                        else state_next = DATA;
                    end
                end
                DATA: begin
                    if (decide) begin
                        if (!sample_bus.bit_stable) state_next = FERROR_LOCK;
                        else if (bit_cnt == BIT_CNT_W'(`UART_DATA_W - 1)) state_next = PARITY;
                    end
                end
                PARITY: begin
                    if (decide) begin
                        if (!sample_bus.bit_stable) state_next = FERROR_LOCK;
                        else if (sample_bus.bit_value != ^push_data) state_next = PERROR_LOCK;
                        else state_next = STOP;
                    end
                end
                STOP: begin
                    if (decide) begin
                        if (sample_bus.bit_stable && sample_bus.bit_value) begin
                            push       = 1'b1; // Byte already complete in push_data
                            state_next = IDLE;
                        end else begin
                            state_next = FERROR_LOCK;
                        end
                    end
                end
                PERROR_LOCK, FERROR_LOCK: state_next = state;
            endcase
        end
    end

    // Flags mirror the lock states
    assign status.ferror = (state == FERROR_LOCK);
    assign status.perror = (state == PERROR_LOCK);

endmodule

//--- src/uart_rx_fifo.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx_fifo (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  logic [`UART_DATA_W-1:0] push_data,
    input  logic                    credit_return,
    output logic                    word_valid,
    output logic [`UART_DATA_W-1:0] word_data,
    output logic                    overrun
);
    localparam int PTR_W  = $clog2(`UART_FIFO_DEPTH);
    localparam int CNT_W  = $clog2(`UART_FIFO_DEPTH + 1);
    localparam int CRED_W = $clog2(`UART_CREDITS + 1);

    logic [`UART_DATA_W-1:0] mem [`UART_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;   // Wraps on its own, depth is 2**n
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;    // Entries held
    logic [CRED_W-1:0]       credits;  // Host credits still available
    logic                    full;
    logic                    wr;
    logic                    fire;     // Launch one word toward the host

    assign full = (count == CNT_W'(`UART_FIFO_DEPTH));
    assign wr   = push && !full;       // Push into a full FIFO is lost
    assign fire = (count != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (wr) mem[wr_ptr] <= push_data;
        if (fire) word_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= CRED_W'(`UART_CREDITS);
            word_valid <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            word_valid <= fire; // Lines up with word_data
            if (wr) wr_ptr <= wr_ptr + 1'b1;
            if (fire) rd_ptr <= rd_ptr + 1'b1;
            if (wr && !fire) count <= count + 1'b1;
            else if (fire && !wr) count <= count - 1'b1;
            // Spend on launch, refill on return, never above the grant
            if (fire && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (!fire && credit_return && credits != CRED_W'(`UART_CREDITS)) begin
                credits <= credits + 1'b1;
            end
            if (push && full) overrun <= 1'b1; // Sticky
        end
    end

endmodule

//--- src/uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler (
    input  logic           clk,
    input  logic           reset,
    input  logic           rxd,
    uart_sample_if.sampler sample_if
);
    logic       rxd_meta;  // First sync stage
    logic       rxd_sync;  // Second sync stage
    logic [2:0] history;   // Newest sample in bit 0

    // Two flop synchronizer, idles high like the line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // One sample per oversample tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            history <= 3'b111;
        end else if (sample_if.tick) begin
            history <= {history[1:0], rxd_sync};
        end
    end

    assign sample_if.rxd_sync = rxd_sync;

    // 2 of 3 vote
    assign sample_if.bit_value = (history[0] & history[1]) |
                                 (history[0] & history[2]) |
                                 (history[1] & history[2]);

    // Unanimous samples only
    assign sample_if.bit_stable = (&history) || !(|history);

endmodule

//--- src/uart_rx_top.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx_top import uart_cfg_pkg::*, uart_frame_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rx_en,
    input  logic [2:0]              baud_select,
    input  logic                    rxd,
    input  logic                    credit_return,
    output logic                    word_valid,
    output logic [`UART_DATA_W-1:0] word_data,
    output logic                    ferror,
    output logic                    perror,
    output logic                    overrun
);
    logic                    push;      // One cycle per good frame
    logic [`UART_DATA_W-1:0] push_data;
    rx_status_t              status;

    uart_receiver u_receiver (
        .clk         (clk),
        .reset       (reset),
        .rx_en       (rx_en),
        .baud_select (baud_sel_t'(baud_select)),
        .rxd         (rxd),
        .push        (push),
        .push_data   (push_data),
        .status      (status)
    );

    uart_rx_fifo u_fifo (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .push_data     (push_data),
        .credit_return (credit_return),
        .word_valid    (word_valid),
        .word_data     (word_data),
        .overrun       (overrun)
    );

    // Error flags out to pins
    assign ferror = status.ferror;
    assign perror = status.perror;

endmodule

//--- src/uart_sample_if.sv
`timescale 1ns/1ps

// Oversample tick and voted line state between baud gen, sampler and FSM
interface uart_sample_if;

    logic tick;       // One clk wide, 16 per bit
    logic rxd_sync;   // Line after the synchronizer
    logic bit_value;  // Majority of last three ticks
    logic bit_stable; // All three samples agree

    modport gen (
        output tick
    );

    modport sampler (
        input  tick,
        output rxd_sync,
        output bit_value,
        output bit_stable
    );

    // Receiver view
    modport rx (
        input tick,
        input rxd_sync,
        input bit_value,
        input bit_stable
    );

endinterface

//--- verification/uart_rx_tb.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx_tb import uart_cfg_pkg::*; ();
    localparam int CLK_NS        = 10;
    localparam int FRAME_BITS    = 13; // Start, data, parity, stop, two idle bits
    localparam int TOTAL_FRAMES  = 36; // Frames plus the glitch over all tests
    localparam int MARGIN_FRAMES = 10;
    localparam int HELD_BYTES    = `UART_CREDITS + `UART_FIFO_DEPTH;

    logic                    clk;
    logic                    reset;
    logic                    rx_en;
    baud_sel_t               baud_select;
    logic                    rxd;
    logic                    credit_return;
    logic                    word_valid;
    logic [`UART_DATA_W-1:0] word_data;
    logic                    ferror;
    logic                    perror;
    logic                    overrun;

    logic [`UART_DATA_W-1:0] exp_q [$];     // Bytes still owed to the host
    logic [`UART_DATA_W-1:0] exp_byte;
    logic [`UART_DATA_W-1:0] data;
    int                      error_count;
    int                      errors_base;   // Errors before the current test
    int                      test_count;
    int                      got_words;     // word_valid pulses seen
    int                      words_base;
    int                      host_cnt;      // FIFO credits as the host counts them
    int                      bit_cycles;    // clk cycles per serial bit
    logic                    hold_credits;  // Host withholds credit returns
    logic                    check_clean;   // Error flags must stay low
    integer                  seed;

    uart_rx_top DUT (
        .clk           (clk),
        .reset         (reset),
        .rx_en         (rx_en),
        .baud_select   (baud_select),
        .rxd           (rxd),
        .credit_return (credit_return),
        .word_valid    (word_valid),
        .word_data     (word_data),
        .ferror        (ferror),
        .perror        (perror),
        .overrun       (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        error_count++;
        $display("error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("at %0t ns: %s", $time, msg);
    endtask

    task automatic start_test();
        errors_base = error_count;
        words_base  = got_words;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %s: %0d error(s)", name, error_count - errors_base);
    endtask

    // Rate changes while the line idles
    task automatic set_rate(input baud_sel_t sel);
        @(negedge clk);
        baud_select = sel;
        bit_cycles  = int'(baud_divisor(sel)) * `UART_OVERSAMPLE;
    endtask

    // Frame is LSB first with even parity
    task automatic send_frame(input logic [7:0] value, input logic bad_parity,
                              input logic low_stop);
        logic [10:0] bits;
        bits = {~low_stop, (^value) ^ bad_parity, value, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            rxd = bits[i];
            repeat (bit_cycles) @(negedge clk);
        end
        rxd = 1'b1;
        repeat (2 * bit_cycles) @(negedge clk); // Idle gap
    endtask

    task automatic send_byte(input logic expect_it);
        data = 8'($random(seed));
        if (expect_it) exp_q.push_back(data);
        send_frame(data, 1'b0, 1'b0);
    endtask

    task automatic wait_for_words(input int target);
        int waited;
        waited = 0;
        while (got_words < target && waited < 2 * FRAME_BITS * bit_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (got_words < target) report_failure($sformatf("timed out waiting for word %0d", target));
    endtask

    task automatic expect_flags(input logic fe, input logic pe);
        assert (ferror === fe) else report_mismatch("ferror", ferror, fe);
        assert (perror === pe) else report_mismatch("perror", perror, pe);
    endtask

    task automatic expect_no_words(input string why);
        assert (got_words == words_base) else report_failure({"word delivered ", why});
    endtask

    // rx_en low for one clock clears any lock
    task automatic pulse_enable();
        @(negedge clk) rx_en = 1'b0;
        @(negedge clk) rx_en = 1'b1;
        @(negedge clk);
    endtask

    // Host credit ledger one edge behind the FIFO
    always @(posedge clk or posedge reset) begin
        if (reset) host_cnt <= `UART_CREDITS;
        else host_cnt <= host_cnt - int'(word_valid) + int'(credit_return);
    end

    // Host returns one credit per cycle unless holding
    initial begin
        credit_return = 1'b0;
        forever begin
            @(negedge clk);
            credit_return = !reset && !hold_credits && (host_cnt < `UART_CREDITS);
        end
    end

    // Scoreboard and protocol checks on the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (word_valid) begin
                got_words++;
                assert (host_cnt > 0) else report_failure("word_valid with no credits left");
                assert (exp_q.size() > 0) else report_failure("word delivered with none expected");
                if (exp_q.size() > 0) begin
                    exp_byte = exp_q.pop_front();
                    assert (word_data === exp_byte)
                        else report_mismatch("word_data", word_data, exp_byte);
                end
            end
            if (check_clean) expect_flags(1'b0, 1'b0);
        end
    end

    // Watchdog sized from the slowest rate in use
    initial begin
        longint limit_ns;
        limit_ns = longint'(TOTAL_FRAMES + MARGIN_FRAMES) * FRAME_BITS * `UART_OVERSAMPLE
                   * baud_divisor(BAUD_57600) * CLK_NS;
        #(limit_ns);
        $display("watchdog expired after %0d ns, run did not complete", limit_ns);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        error_count  = 0;
        test_count   = 0;
        got_words    = 0;
        seed         = 32'h8bc2_97ab;
        hold_credits = 1'b0;
        check_clean  = 1'b0;
        reset        = 1'b1;
        rx_en        = 1'b0;
        rxd          = 1'b1;
        baud_select  = BAUD_115200;
        bit_cycles   = int'(baud_divisor(BAUD_115200)) * `UART_OVERSAMPLE;
        repeat (5) @(posedge clk);
        @(negedge clk) reset = 1'b0;

        // Clean bytes at two rates
        start_test();
        check_clean = 1'b1;
        rx_en       = 1'b1;
        repeat (8) send_byte(1'b1);
        set_rate(BAUD_57600);
        repeat (8) send_byte(1'b1);
        wait_for_words(words_base + 16);
        end_test("clean frames");

        // Back-pressure then overrun on the last two bytes
        start_test();
        set_rate(BAUD_115200);
        assert (overrun === 1'b0) else report_mismatch("overrun", overrun, 1'b0);
        hold_credits = 1'b1;
        for (int i = 0; i < HELD_BYTES + 2; i++) send_byte(i < HELD_BYTES);
        assert (got_words - words_base == `UART_CREDITS)
            else report_mismatch("delivered words", got_words - words_base, `UART_CREDITS);
        assert (overrun === 1'b1) else report_mismatch("overrun", overrun, 1'b1);
        hold_credits = 1'b0;
        wait_for_words(words_base + HELD_BYTES);
        assert (exp_q.size() == 0) else report_failure("held bytes were not all delivered");
        check_clean = 1'b0;
        end_test("credit back-pressure");

        // Parity lock cleared by rx_en
        start_test();
        send_frame(8'($random(seed)), 1'b1, 1'b0);
        expect_flags(1'b0, 1'b1);
        send_byte(1'b0); // Ignored while locked
        expect_flags(1'b0, 1'b1);
        expect_no_words("after a parity error");
        pulse_enable();
        expect_flags(1'b0, 1'b0);
        send_byte(1'b1);
        wait_for_words(words_base + 1);
        end_test("parity error");

        // Framing lock from a low stop bit
        start_test();
        send_frame(8'($random(seed)), 1'b0, 1'b1);
        expect_flags(1'b1, 1'b0);
        send_byte(1'b0);
        expect_flags(1'b1, 1'b0);
        expect_no_words("after a framing error");
        pulse_enable();
        expect_flags(1'b0, 1'b0);
        send_byte(1'b1);
        wait_for_words(words_base + 1);
        end_test("framing error");

        // Disabled line then a short start glitch
        start_test();
        check_clean = 1'b1;
        @(negedge clk) rx_en = 1'b0;
        repeat (2) send_byte(1'b0);
        expect_no_words("while rx_en was low");
        @(negedge clk) rx_en = 1'b1;
        rxd = 1'b0;
        repeat (bit_cycles / 4) @(negedge clk); // Quarter bit is under half a bit
        rxd = 1'b1;
        repeat (FRAME_BITS * bit_cycles) @(negedge clk);
        expect_no_words("after a start glitch");
        send_byte(1'b1);
        wait_for_words(words_base + 1);
        check_clean = 1'b0;
        end_test("disabled and false start");

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
